// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := tb_hdmi_text
FILELIST  := tb.f
RUN_FLAGS := +verilator+error+limit+1000

SOURCES   := $(shell grep -v '^+' $(FILELIST))
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Simulation PASSED

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: source/axi_read_channel.sv
`timescale 1ns/1ps

module axi_read_channel import hdmi_text_pkg::*; (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  input  logic [axi_addr_w-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  output word_t                 rdata,
  output logic                  rvalid,
  input  logic                  rready,
  output vram_idx_t             rd_addr,
  input  word_t                 rd_data
);

  // address captured at accept
  axi_addr_u araddr_q;
  // memory latency cycle, one pulse
  logic      pending;
  // start of a new read
  logic      accept;

  // --------------------------------------------------
  // read address handshake
  // --------------------------------------------------

  // no new read while one is in flight or unclaimed
  assign accept = ~arready && arvalid && ~rvalid && ~pending;

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      arready <= 1'b0;
      pending <= 1'b0;
    end
    else
    begin
      arready <= accept;
      // memory samples rd_addr at the handshake edge
      pending <= arready && arvalid;
    end
  end

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (accept)
      araddr_q <= araddr;
  end

  // reads always go to VRAM, select bit ignored
  assign rd_addr = araddr_q.vram.idx;

  // --------------------------------------------------
  // read data return
  // --------------------------------------------------

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      rvalid <= 1'b0;
    else if (pending)
      rvalid <= 1'b1;
    else if (rvalid && rready)
      rvalid <= 1'b0;
  end

  // hold register keeps RDATA stable under back-pressure
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (pending)
      rdata <= rd_data;
  end

endmodule

// File: source/axi_write_channel.sv
`timescale 1ns/1ps

module axi_write_channel import hdmi_text_pkg::*; (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  input  logic [axi_addr_w-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  input  word_t                 wdata,
  input  strb_t                 wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  output logic                  bvalid,
  input  logic                  bready,
  vram_wr_if.source             wr
);

  // high from accept until the response is taken
  logic      outstanding;
  // accept condition, sampled at the edge
  logic      accept;
  // both channels handshaking in the ready cycle
  logic      wr_fire;
  // address captured at accept
  axi_addr_u addr_q;

  // --------------------------------------------------
  // address and data handshake
  // --------------------------------------------------

  // AW and W must both be present, one write in flight
  assign accept  = ~awready && awvalid && wvalid && ~outstanding;
  assign wr_fire = awready && awvalid && wready && wvalid;

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      awready     <= 1'b0;
      wready      <= 1'b0;
      outstanding <= 1'b0;
    end
    else
    begin
      // both readies pulse together for one cycle
      awready <= accept;
      wready  <= accept;
      if (accept)
        outstanding <= 1'b1;
      else if (bvalid && bready)
        outstanding <= 1'b0;
    end
  end

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (accept)
      addr_q <= awaddr;
  end

  // --------------------------------------------------
  // write response
  // --------------------------------------------------

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      bvalid <= 1'b0;
    else if (wr_fire)
      bvalid <= 1'b1;
    else if (bvalid && bready)
      bvalid <= 1'b0;
  end

  // store write goes out during the ready cycle
  // data and strobe still held by the master here
  assign wr.en   = wr_fire;
  assign wr.addr = addr_q;
  assign wr.data = wdata;
  assign wr.strb = wstrb;

endmodule

// File: source/hdmi_text_axi_regs.sv
`timescale 1ns/1ps

module hdmi_text_axi_regs import hdmi_text_pkg::*; (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  // write address channel
  input  logic [axi_addr_w-1:0] s_axi_awaddr,
  input  logic                  s_axi_awvalid,
  output logic                  s_axi_awready,
  // write data channel
  input  word_t                 s_axi_wdata,
  input  strb_t                 s_axi_wstrb,
  input  logic                  s_axi_wvalid,
  output logic                  s_axi_wready,
  // write response channel
  output logic [1:0]            s_axi_bresp,
  output logic                  s_axi_bvalid,
  input  logic                  s_axi_bready,
  // read address channel
  input  logic [axi_addr_w-1:0] s_axi_araddr,
  input  logic                  s_axi_arvalid,
  output logic                  s_axi_arready,
  // read data channel
  output word_t                 s_axi_rdata,
  output logic [1:0]            s_axi_rresp,
  output logic                  s_axi_rvalid,
  input  logic                  s_axi_rready,
  // display side
  input  vram_idx_t             disp_index,
  output word_t                 disp_word,
  output word_t                 palette [palette_entries]
);

  // bus read request into the store
  vram_idx_t rd_addr;
  word_t     rd_data;

  // write path from channel to store
  vram_wr_if wr_bus ();

  // no error cases, every transfer is OKAY
  assign s_axi_bresp = resp_okay;
  assign s_axi_rresp = resp_okay;

  // --------------------------------------------------
  // channels, running side by side
  // --------------------------------------------------

  axi_write_channel u_write (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (s_axi_awaddr),
    .awvalid       (s_axi_awvalid),
    .awready       (s_axi_awready),
    .wdata         (s_axi_wdata),
    .wstrb         (s_axi_wstrb),
    .wvalid        (s_axi_wvalid),
    .wready        (s_axi_wready),
    .bvalid        (s_axi_bvalid),
    .bready        (s_axi_bready),
    .wr            (wr_bus.source)
  );

  axi_read_channel u_read (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .araddr        (s_axi_araddr),
    .arvalid       (s_axi_arvalid),
    .arready       (s_axi_arready),
    .rdata         (s_axi_rdata),
    .rvalid        (s_axi_rvalid),
    .rready        (s_axi_rready),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data)
  );

  // store merges both request streams
  vram_palette_space u_space (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr            (wr_bus.sink),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .disp_index    (disp_index),
    .disp_word     (disp_word),
    .palette       (palette)
  );

endmodule

// File: source/hdmi_text_pkg.sv
package hdmi_text_pkg;

  // --------------------------------------------------
  // bus and store sizes
  // --------------------------------------------------

  localparam int axi_addr_w      = 16;
  localparam int axi_data_w      = 32;
  // one strobe bit per byte lane
  localparam int strb_w          = axi_data_w / 8;
  localparam int vram_idx_w      = 11;
  localparam int vram_words      = 2048;
  localparam int palette_entries = 8;
  localparam int palette_idx_w   = 3;

  // only response ever returned
  localparam logic [1:0] resp_okay = 2'b00;

  // --------------------------------------------------
  // data types
  // --------------------------------------------------

  typedef logic [axi_data_w-1:0] word_t;
  typedef logic [strb_w-1:0]     strb_t;
  typedef logic [vram_idx_w-1:0] vram_idx_t;

  // one bus address seen two ways
  // bit 13 picks the palette, same place in both views
  typedef union packed {
    struct packed {
      logic [1:0] spare;
      logic       sel;
      vram_idx_t  idx;
      logic [1:0] byte_off;
    } vram;
    struct packed {
      logic [1:0]               spare;
      logic                     sel;
      // word index bits above the palette range
      logic [7:0]               unused;
      logic [palette_idx_w-1:0] idx;
      logic [1:0]               byte_off;
    } pal;
  } axi_addr_u;

endpackage

// File: source/text_vram.sv
`timescale 1ns/1ps

module text_vram import hdmi_text_pkg::*; (
  input  logic      S_AXI_ACLK,
  // write port, zero strobe means no write
  input  vram_idx_t we_index,
  input  strb_t     we_strb,
  input  word_t     we_data,
  // bus read port
  input  vram_idx_t ra_index,
  output word_t     ra_data,
  // display read port
  input  vram_idx_t rb_index,
  output word_t     rb_data
);

  // character and attribute words
  word_t mem [vram_words];

  // --------------------------------------------------
  // byte-enabled write
  // --------------------------------------------------

  always_ff @(posedge S_AXI_ACLK)
  begin
    for (int b = 0; b < strb_w; b++)
    begin
      if (we_strb[b])
        mem[we_index][b*8 +: 8] <= we_data[b*8 +: 8];
    end
  end

  // --------------------------------------------------
  // registered reads
  // --------------------------------------------------

  // old data returned on a same-cycle collision
  always_ff @(posedge S_AXI_ACLK)
  begin
    ra_data <= mem[ra_index];
  end

  // display side runs free of the bus
  always_ff @(posedge S_AXI_ACLK)
  begin
    rb_data <= mem[rb_index];
  end

endmodule

// File: source/vram_palette_space.sv
`timescale 1ns/1ps

module vram_palette_space import hdmi_text_pkg::*; (
  input  logic      S_AXI_ACLK,
  input  logic      S_AXI_ARESETN,
  vram_wr_if.sink   wr,
  // bus read, data one cycle after the index
  input  vram_idx_t rd_addr,
  output word_t     rd_data,
  // display read, same latency
  input  vram_idx_t disp_index,
  output word_t     disp_word,
  // colour table, always visible to the display
  output word_t     palette [palette_entries]
);

  // write lands in the palette
  logic  pal_we;
  // byte enables toward VRAM, zero when not a VRAM write
  strb_t vram_strb;

  // --------------------------------------------------
  // write decode
  // --------------------------------------------------

  // bit 13 set selects the palette
  assign pal_we = wr.en && wr.addr.pal.sel;

  // strobes only pass for a VRAM write
  always_comb
  begin
    vram_strb = '0;
    if (wr.en && !wr.addr.vram.sel)
      vram_strb = wr.strb;
  end

  text_vram u_text_vram (
    .S_AXI_ACLK (S_AXI_ACLK),
    .we_index   (wr.addr.vram.idx),
    .we_strb    (vram_strb),
    .we_data    (wr.data),
    .ra_index   (rd_addr),
    .ra_data    (rd_data),
    .rb_index   (disp_index),
    .rb_data    (disp_word)
  );

  // --------------------------------------------------
  // palette registers
  // --------------------------------------------------

  // whole word stored, strobe has no effect here
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      for (int i = 0; i < palette_entries; i++)
        palette[i] <= '0;
    end
    else if (pal_we)
    begin
      // entry from address bits 4:2
      palette[wr.addr.pal.idx] <= wr.data;
    end
  end

endmodule

// File: source/vram_wr_if.sv
`timescale 1ns/1ps

interface vram_wr_if import hdmi_text_pkg::*; ();

  // single-cycle write strobe, no back-pressure
  logic      en;
  // full bus address, decoded by the store
  axi_addr_u addr;
  word_t     data;
  // byte lanes, ignored for palette writes
  strb_t     strb;

  // write channel side
  modport source (
    output en,
    output addr,
    output data,
    output strb
  );

  // store side
  modport sink (
    input en,
    input addr,
    input data,
    input strb
  );

endinterface

// File: tb.f
source/hdmi_text_pkg.sv
source/vram_wr_if.sv
source/text_vram.sv
source/vram_palette_space.sv
source/axi_write_channel.sv
source/axi_read_channel.sv
source/hdmi_text_axi_regs.sv
tests/hdmi_text_checker.sv
tests/tb_hdmi_text.sv

// File: tests/hdmi_text_checker.sv
`timescale 1ns/1ps

module hdmi_text_checker import hdmi_text_pkg::*; (
  input logic       S_AXI_ACLK,
  input logic       S_AXI_ARESETN,
  input logic       s_axi_awvalid,
  input logic       s_axi_awready,
  input logic       s_axi_wvalid,
  input logic       s_axi_wready,
  input logic [1:0] s_axi_bresp,
  input logic       s_axi_bvalid,
  input logic       s_axi_bready,
  input logic       s_axi_arvalid,
  input logic       s_axi_arready,
  input word_t      s_axi_rdata,
  input logic [1:0] s_axi_rresp,
  input logic       s_axi_rvalid,
  input logic       s_axi_rready
);

  // failures seen so far for the testbench to read
  int   err_count = 0;
  // write accepted on this edge
  logic aw_fire;
  // read address accepted on this edge
  logic ar_fire;

  assign aw_fire = s_axi_awready && s_axi_awvalid && s_axi_wready && s_axi_wvalid;
  assign ar_fire = s_axi_arready && s_axi_arvalid;

  // --------------------------------------------------
  // reset and write channel
  // --------------------------------------------------

  // a reset edge clears every ready and valid
  reset_idle: assert property (@(posedge S_AXI_ACLK) !S_AXI_ARESETN |=>
    !(s_axi_awready || s_axi_wready || s_axi_bvalid || s_axi_arready || s_axi_rvalid))
    else
    begin
      err_count++;
      $error("ready or valid high after a reset edge");
    end

  ready_pair: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_awready == s_axi_wready)
    else
    begin
      err_count++;
      $error("awready and wready out of step");
    end

  ready_single: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_awready |=> !s_axi_awready)
    else
    begin
      err_count++;
      $error("awready held for more than one cycle");
    end

  // response follows the accept edge directly
  b_start: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    $rose(s_axi_bvalid) == $past(aw_fire))
    else
    begin
      err_count++;
      $error("bvalid not raised right after the write accept");
    end

  b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
    else
    begin
      err_count++;
      $error("bvalid dropped before bready");
    end

  // one write in flight at a time
  no_second_write: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_bvalid |-> !s_axi_awready)
    else
    begin
      err_count++;
      $error("new write accepted while response pending");
    end

  // --------------------------------------------------
  // read channel
  // --------------------------------------------------

  r_latency: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    $rose(s_axi_rvalid) == $past(ar_fire, 2))
    else
    begin
      err_count++;
      $error("rvalid not two cycles after the read accept");
    end

  r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
    else
    begin
      err_count++;
      $error("read data dropped or changed before rready");
    end

  resp_always_okay: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_bresp == resp_okay && s_axi_rresp == resp_okay)
    else
    begin
      err_count++;
      $error("response code other than OKAY");
    end

endmodule

bind hdmi_text_axi_regs hdmi_text_checker u_checker (.*);

// File: tests/tb_hdmi_text.sv
`timescale 1ns/1ps

module tb_hdmi_text import hdmi_text_pkg::*; ();

  logic                  S_AXI_ACLK = 1'b0;
  logic                  S_AXI_ARESETN;
  logic [axi_addr_w-1:0] s_axi_awaddr;
  logic                  s_axi_awvalid;
  logic                  s_axi_awready;
  word_t                 s_axi_wdata;
  strb_t                 s_axi_wstrb;
  logic                  s_axi_wvalid;
  logic                  s_axi_wready;
  logic [1:0]            s_axi_bresp;
  logic                  s_axi_bvalid;
  logic                  s_axi_bready;
  logic [axi_addr_w-1:0] s_axi_araddr;
  logic                  s_axi_arvalid;
  logic                  s_axi_arready;
  word_t                 s_axi_rdata;
  logic [1:0]            s_axi_rresp;
  logic                  s_axi_rvalid;
  logic                  s_axi_rready;
  vram_idx_t             disp_index;
  word_t                 disp_word;
  word_t                 palette [palette_entries];

  // shadow copies of both stores
  word_t     vram_model [vram_words];
  word_t     pal_model [palette_entries];
  // indices holding defined data
  vram_idx_t written [$];
  int        mismatches = 0;
  int        timeouts = 0;
  // cycles allowed for any single wait
  int        wait_limit = 40;

  always #50 S_AXI_ACLK = ~S_AXI_ACLK;

  hdmi_text_axi_regs UUT (.*);

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------

  // inputs move 1 ns after the edge
  task automatic tick();
    @(posedge S_AXI_ACLK);
    #1;
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    assert (got === exp)
    else
    begin
      mismatches++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    $display("timeout while waiting for %s", what);
  endtask

  task automatic check_palette();
    for (int i = 0; i < palette_entries; i++)
      check_word($sformatf("palette[%0d]", i), palette[i], pal_model[i]);
  endtask

  // --------------------------------------------------
  // bus tasks
  // --------------------------------------------------

  task automatic axi_write(input logic [axi_addr_w-1:0] addr, input word_t data,
                           input strb_t strb, input int hold);
    int n;
    int pulses;
    n = 0;
    pulses = 0;
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    while (!s_axi_awready && n < wait_limit)
    begin
      tick();
      n++;
    end
    if (!s_axi_awready)
      note_timeout("s_axi_awready");
    n = 0;
    // valids held through the response so a second accept would show here
    while (!s_axi_bvalid && n < wait_limit)
    begin
      if (s_axi_awready)
        pulses++;
      tick();
      n++;
    end
    if (!s_axi_bvalid)
      note_timeout("s_axi_bvalid");
    // hold off B for a while then take the response
    for (int c = 0; c <= hold + 2; c++)
    begin
      if (s_axi_awready)
        pulses++;
      s_axi_bready = (c == hold);
      if (c == hold + 1)
      begin
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
      end
      tick();
    end
    check_word("s_axi_awready pulse count", word_t'(pulses), 32'd1);
    // model update straight from the address map
    if (addr[13])
      pal_model[addr[4:2]] = data;
    else
      for (int b = 0; b < strb_w; b++)
        if (strb[b])
          vram_model[addr[12:2]][b*8 +: 8] = data[b*8 +: 8];
  endtask

  task automatic axi_read(input logic [axi_addr_w-1:0] addr, input int hold,
                          output word_t data);
    int n;
    n = 0;
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    while (!s_axi_arready && n < wait_limit)
    begin
      tick();
      n++;
    end
    if (!s_axi_arready)
      note_timeout("s_axi_arready");
    tick();
    s_axi_arvalid = 1'b0;
    n = 0;
    while (!s_axi_rvalid && n < wait_limit)
    begin
      tick();
      n++;
    end
    if (!s_axi_rvalid)
      note_timeout("s_axi_rvalid");
    data = s_axi_rdata;
    check_word("s_axi_rresp", word_t'(s_axi_rresp), word_t'(resp_okay));
    // data must not move while RREADY is low
    repeat (hold)
    begin
      tick();
      check_word("s_axi_rdata under back-pressure", s_axi_rdata, data);
    end
    s_axi_rready = 1'b1;
    tick();
    s_axi_rready = 1'b0;
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------

  initial
  begin
    vram_idx_t             idx;
    word_t                 rd_word;
    logic [axi_addr_w-1:0] addr;
    int                    assert_fails;
    void'($urandom(59335));
    S_AXI_ARESETN = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    disp_index    = '0;
    foreach (pal_model[i])
      pal_model[i] = '0;
    repeat (4) @(posedge S_AXI_ACLK);
    #1;
    S_AXI_ARESETN = 1'b1;
    check_word("ready and valid outputs after reset", word_t'({s_axi_awready, s_axi_wready,
               s_axi_bvalid, s_axi_arready, s_axi_rvalid}), '0);
    check_palette();

    // full-word writes then read-back
    repeat (20)
    begin
      idx = vram_idx_t'($urandom);
      axi_write({2'b00, 1'b0, idx, 2'b00}, $urandom, 4'hf, $urandom_range(0, 3));
      written.push_back(idx);
    end
    foreach (written[i])
    begin
      axi_read({2'b00, 1'b0, written[i], 2'b00}, $urandom_range(0, 4), rd_word);
      check_word("s_axi_rdata", rd_word, vram_model[written[i]]);
    end

    // partial strobes merge into words already defined
    repeat (12)
    begin
      idx  = written[$urandom_range(0, written.size() - 1)];
      addr = {2'b00, 1'b0, idx, 2'b00};
      axi_write(addr, $urandom, strb_t'($urandom_range(1, 14)), $urandom_range(0, 3));
      axi_read(addr, $urandom_range(0, 2), rd_word);
      check_word("s_axi_rdata after strobed write", rd_word, vram_model[idx]);
    end

    // palette writes ignore the strobe and leave VRAM alone
    repeat (8)
    begin
      idx  = written[$urandom_range(0, written.size() - 1)];
      addr = {2'b00, 1'b1, idx, 2'b00};
      axi_write(addr, $urandom, strb_t'($urandom), $urandom_range(0, 3));
      check_palette();
      axi_read(addr, 0, rd_word);
      check_word("s_axi_rdata behind palette", rd_word, vram_model[idx]);
    end

    // display port runs one cycle behind the index
    repeat (10)
    begin
      idx = written[$urandom_range(0, written.size() - 1)];
      disp_index = idx;
      tick();
      check_word("disp_word", disp_word, vram_model[idx]);
    end

    tick();
    assert_fails = UUT.u_checker.err_count;
    $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, assert_fails);
    if (mismatches + timeouts + assert_fails == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule
